//--- include/sha_hub_defines.svh
`ifndef SHA_HUB_DEFINES_SVH
`define SHA_HUB_DEFINES_SVH

// --------------------------------------------------
// bus geometry
// --------------------------------------------------
`define SHA_DATA_W 32          // bus data and message word width
`define SHA_ADDR_W 12          // decoded part of the byte address, 4 KiB window

// message word queue
`define SHA_FIFO_DEPTH 16      // one 512-bit block, power of two

// read-only version word, major.minor in the upper half, build below
`define SHA_VERSION 32'h0102_0001

// --------------------------------------------------
// control register bit positions
// --------------------------------------------------
`define CTRL_ENABLE_BIT 0      // same spot in REG_CTRL and REG_SHA_CTRL
`define SHA_CTRL_INIT_BIT 1    // self-clearing, restarts the hash

`endif

//--- hdl/sha_bus_pkg.sv
`include "sha_hub_defines.svh"

package sha_bus_pkg;

  // AXI response codes, only the two this slave can give
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10  // push while the fifo is full
  } axi_resp_e;

  // register byte addresses
  typedef enum logic [`SHA_ADDR_W-1:0] {
    REG_CTRL       = 12'h000,  // global enable
    REG_STATUS     = 12'h004,
    REG_VERSION    = 12'h00C,
    REG_SHA_CTRL   = 12'h100,  // engine enable, init
    REG_SHA_STATUS = 12'h104,
    REG_SHA_PUSH   = 12'h10C,  // write only, feeds the word fifo
    REG_HASH_H7    = 12'h110,  // least significant digest word first
    REG_HASH_H6    = 12'h114,
    REG_HASH_H5    = 12'h118,
    REG_HASH_H4    = 12'h11C,
    REG_HASH_H3    = 12'h120,
    REG_HASH_H2    = 12'h124,
    REG_HASH_H1    = 12'h128,
    REG_HASH_H0    = 12'h12C   // most significant word
  } reg_addr_e;

  // master to slave
  typedef struct packed {
    logic                       awvalid;
    logic [`SHA_ADDR_W-1:0]     awaddr;
    logic                       wvalid;
    logic [`SHA_DATA_W-1:0]     wdata;
    logic [`SHA_DATA_W/8-1:0]   wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [`SHA_ADDR_W-1:0]     araddr;
    logic                       rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    axi_resp_e                  bresp;
    logic                       arready;
    logic                       rvalid;
    logic [`SHA_DATA_W-1:0]     rdata;
    axi_resp_e                  rresp;
  } axil_rsp_t;

endpackage

//--- hdl/sha256_pkg.sv
`include "sha_hub_defines.svh"

package sha256_pkg;

  typedef logic [31:0] word_t;  // sha-256 works on 32-bit words

  typedef enum logic [1:0] {
    IDLE,   // waiting for a block
    LOAD,   // pulling 16 words from the fifo
    ROUND,  // 64 compression rounds
    ACCUM   // fold a..h into the running hash
  } core_state_e;

  // H0 sits in the top word
  typedef struct packed {
    word_t h0;
    word_t h1;
    word_t h2;
    word_t h3;
    word_t h4;
    word_t h5;
    word_t h6;
    word_t h7;
  } digest_t;

  typedef struct packed {
    logic                             core_ready;
    logic                             hash_valid;
    logic                             fifo_empty;
    logic                             fifo_full;
    logic [$clog2(`SHA_FIFO_DEPTH):0] fifo_count;  // 0 up to depth
  } hub_status_t;

  typedef struct packed {
    logic enable;  // engine and global enable together
    logic init;    // one-cycle restart pulse
  } sha_ctrl_t;

  // --------------------------------------------------
  // constants from FIPS 180-4
  // --------------------------------------------------
  localparam digest_t SHA_IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  localparam word_t SHA_K [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // --------------------------------------------------
  // round helpers
  // --------------------------------------------------
  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic word_t big_sigma0(word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic word_t big_sigma1(word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic word_t small_sigma0(word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic word_t small_sigma1(word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic word_t choose(word_t e, word_t f, word_t g);
    return (e & f) ^ (~e & g);   // e picks f or g bitwise
  endfunction

  function automatic word_t majority(word_t a, word_t b, word_t c);
    return (a & b) ^ (a & c) ^ (b & c);
  endfunction

endpackage

//--- hdl/word_fifo.sv
`timescale 1ns/10ps
`include "sha_hub_defines.svh"

module word_fifo #(
  parameter int  DEPTH = `SHA_FIFO_DEPTH,  // power of two, pointers wrap freely
  localparam int PTR_W = $clog2(DEPTH)
) (
  input  logic                   bus_clk,
  input  logic                   bus_rstn,
  input  logic                   flush_i,      // drops every stored word
  input  logic                   push_i,
  input  logic [`SHA_DATA_W-1:0] push_data_i,
  input  logic                   pop_i,
  output logic [`SHA_DATA_W-1:0] rd_data_o,    // head word, valid while not empty
  output logic                   empty_o,
  output logic                   full_o,
  output logic [PTR_W:0]         count_o
);

  logic [`SHA_DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic                   do_push;
  logic                   do_pop;

  assign do_push   = push_i && !full_o;   // overflow is silently dropped
  assign do_pop    = pop_i && !empty_o;
  assign empty_o   = (count_o == '0);
  assign full_o    = (count_o == (PTR_W + 1)'(DEPTH));
  assign rd_data_o = mem[rd_ptr];        // first word falls through

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || flush_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;         // idle or both, level unchanged
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (do_push) mem[wr_ptr] <= push_data_i;
  end

endmodule

//--- hdl/sha256_core.sv
`timescale 1ns/10ps
`include "sha_hub_defines.svh"

module sha256_core
  import sha256_pkg::*;
(
  input  logic                   bus_clk,
  input  logic                   bus_rstn,
  input  sha_ctrl_t              ctrl_i,
  input  logic                   fifo_empty_i,
  input  logic [`SHA_DATA_W-1:0] fifo_data_i,   // fwft head of the word fifo
  output logic                   pop_o,
  output logic                   ready_o,
  output logic                   hash_valid_o,  // block done, held until next start
  output digest_t                digest_o
);

  core_state_e  state;
  logic [5:0]   cnt;     // word index in LOAD, round index in ROUND
  word_t [15:0] w;       // schedule window, w[0] is W[t]
  digest_t      work;    // working vars a..h kept in h0..h7
  digest_t      hash;    // running hash, chains across blocks
  word_t        w_next;
  word_t        t1;
  word_t        t2;

  assign pop_o    = (state == LOAD) && !fifo_empty_i;  // one word per cycle, stall on empty
  assign ready_o  = (state == IDLE);
  assign digest_o = hash;

  // --------------------------------------------------
  // round datapath
  // --------------------------------------------------
  // W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
  assign w_next = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0];

  assign t1 = work.h7 + big_sigma1(work.h4) + choose(work.h4, work.h5, work.h6)
            + SHA_K[cnt] + w[0];
  assign t2 = big_sigma0(work.h0) + majority(work.h0, work.h1, work.h2);

  always_ff @(posedge bus_clk) begin
    case (state)
      LOAD: begin
        work <= hash;                              // a..h start from the running hash
        if (pop_o) w <= {fifo_data_i, w[15:1]};    // first word ends up in w[0]
      end
      ROUND: begin
        // a <= t1+t2, e <= d+t1, the rest move down one place
        work <= {t1 + t2, work.h0, work.h1, work.h2,
                 work.h3 + t1, work.h4, work.h5, work.h6};
        w    <= {w_next, w[15:1]};
      end
      default: begin
        work <= work;
        w    <= w;
      end
    endcase
  end

  // --------------------------------------------------
  // control FSM and hash accumulation
  // --------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || ctrl_i.init) begin
      state        <= IDLE;
      cnt          <= '0;
      hash         <= SHA_IV;
      hash_valid_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (ctrl_i.enable && !fifo_empty_i) begin
            state        <= LOAD;
            cnt          <= '0;
            hash_valid_o <= 1'b0;   // new block, old result goes stale
          end
        end
        LOAD: begin
          if (pop_o) begin
            if (cnt == 6'd15) begin
              state <= ROUND;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 6'd1;
            end
          end
        end
        ROUND: begin
          cnt <= cnt + 6'd1;        // wraps to 0 after round 63
          if (cnt == 6'd63) state <= ACCUM;
        end
        ACCUM: begin
          hash.h0      <= hash.h0 + work.h0;
          hash.h1      <= hash.h1 + work.h1;
          hash.h2      <= hash.h2 + work.h2;
          hash.h3      <= hash.h3 + work.h3;
          hash.h4      <= hash.h4 + work.h4;
          hash.h5      <= hash.h5 + work.h5;
          hash.h6      <= hash.h6 + work.h6;
          hash.h7      <= hash.h7 + work.h7;
          hash_valid_o <= 1'b1;
          state        <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- hdl/axil_reg_slave.sv
`timescale 1ns/10ps
`include "sha_hub_defines.svh"

module axil_reg_slave
  import sha_bus_pkg::*;
  import sha256_pkg::*;
(
  input  logic                   bus_clk,
  input  logic                   bus_rstn,
  input  axil_req_t              req_i,
  output axil_rsp_t              rsp_o,
  input  hub_status_t            status_i,
  input  digest_t                digest_i,
  output sha_ctrl_t              ctrl_o,
  output logic                   push_valid_o,
  output logic [`SHA_DATA_W-1:0] push_data_o
);

  logic                   glb_en;      // REG_CTRL enable
  logic                   sha_en;      // REG_SHA_CTRL enable
  logic                   init_q;      // restart pulse to core and fifo
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_push;
  logic                   ctrl_lane;
  logic                   bvalid_q;
  logic                   rvalid_q;
  axi_resp_e              bresp_q;
  logic [`SHA_DATA_W-1:0] rdata_q;
  logic [`SHA_DATA_W-1:0] rd_mux;
  reg_addr_e              wr_addr;
  reg_addr_e              rd_addr;

  assign wr_addr = reg_addr_e'(req_i.awaddr);
  assign rd_addr = reg_addr_e'(req_i.araddr);

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------
  assign wr_fire   = req_i.awvalid && req_i.wvalid && !bvalid_q;  // aw and w taken together
  assign rd_fire   = req_i.arvalid && !rvalid_q;
  assign wr_push   = wr_fire && (wr_addr == REG_SHA_PUSH);
  assign ctrl_lane = wr_fire && req_i.wstrb[0];                   // control bits live in byte 0

  assign push_valid_o = wr_push && !status_i.fifo_full;  // full fifo drops the word
  assign push_data_o  = req_i.wdata;

  assign ctrl_o.enable = glb_en && sha_en;
  assign ctrl_o.init   = init_q;

  always_comb begin
    rsp_o.awready = wr_fire;
    rsp_o.wready  = wr_fire;
    rsp_o.bvalid  = bvalid_q;
    rsp_o.bresp   = bresp_q;
    rsp_o.arready = rd_fire;
    rsp_o.rvalid  = rvalid_q;
    rsp_o.rdata   = rdata_q;
    rsp_o.rresp   = OKAY;      // every read address answers, unmapped as 0
  end

  // --------------------------------------------------
  // control registers and init pulse
  // --------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      glb_en <= 1'b0;
      sha_en <= 1'b0;
      init_q <= 1'b0;
    end else begin
      init_q <= 1'b0;                                  // self-clearing
      if (ctrl_lane) begin
        case (wr_addr)
          REG_CTRL: begin
            glb_en <= req_i.wdata[`CTRL_ENABLE_BIT];
            if (glb_en && !req_i.wdata[`CTRL_ENABLE_BIT]) begin
              sha_en <= 1'b0;                          // global off restarts the engine
              init_q <= 1'b1;
            end
          end
          REG_SHA_CTRL: begin
            // an init write leaves the engine disabled
            sha_en <= req_i.wdata[`CTRL_ENABLE_BIT] && !req_i.wdata[`SHA_CTRL_INIT_BIT];
            init_q <= req_i.wdata[`SHA_CTRL_INIT_BIT];
          end
          default: ;                                   // unmapped, ignored
        endcase
      end
    end
  end

  // --------------------------------------------------
  // response valids
  // --------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire)           bvalid_q <= 1'b1;
      else if (req_i.bready) bvalid_q <= 1'b0;
      if (rd_fire)           rvalid_q <= 1'b1;
      else if (req_i.rready) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (wr_fire) bresp_q <= (wr_push && status_i.fifo_full) ? SLVERR : OKAY;
    if (rd_fire) rdata_q <= rd_mux;
  end

  // read mux
  always_comb begin
    rd_mux = '0;
    case (rd_addr)
      REG_CTRL:       rd_mux[`CTRL_ENABLE_BIT] = glb_en;
      REG_STATUS: begin
        rd_mux[0] = glb_en;
        rd_mux[4] = ctrl_o.enable;                     // engine actually running
      end
      REG_VERSION:    rd_mux = `SHA_VERSION;
      REG_SHA_CTRL:   rd_mux[`CTRL_ENABLE_BIT] = sha_en; // init bit reads 0
      REG_SHA_STATUS: begin
        rd_mux[0]    = status_i.core_ready;
        rd_mux[1]    = status_i.hash_valid;
        rd_mux[4]    = status_i.fifo_empty;
        rd_mux[6]    = status_i.fifo_full;
        rd_mux[12:8] = status_i.fifo_count;
      end
      REG_HASH_H7:    rd_mux = digest_i.h7;
      REG_HASH_H6:    rd_mux = digest_i.h6;
      REG_HASH_H5:    rd_mux = digest_i.h5;
      REG_HASH_H4:    rd_mux = digest_i.h4;
      REG_HASH_H3:    rd_mux = digest_i.h3;
      REG_HASH_H2:    rd_mux = digest_i.h2;
      REG_HASH_H1:    rd_mux = digest_i.h1;
      REG_HASH_H0:    rd_mux = digest_i.h0;
      default:        rd_mux = '0;                     // push reg and holes
    endcase
  end

endmodule

//--- hdl/sha_hub_top.sv
`timescale 1ns/10ps
`include "sha_hub_defines.svh"

module sha_hub_top
  import sha_bus_pkg::*;
  import sha256_pkg::*;
(
  input  logic      bus_clk,
  input  logic      bus_rstn,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o
);

  sha_ctrl_t                        ctrl;
  hub_status_t                      status;
  digest_t                          digest;
  logic                             push_valid;
  logic [`SHA_DATA_W-1:0]           push_data;
  logic                             pop;
  logic [`SHA_DATA_W-1:0]           fifo_data;
  logic                             fifo_empty;
  logic                             fifo_full;
  logic [$clog2(`SHA_FIFO_DEPTH):0] fifo_count;
  logic                             core_ready;
  logic                             hash_valid;

  // status word seen by the register slave
  assign status = '{core_ready: core_ready, hash_valid: hash_valid, fifo_empty: fifo_empty,
                    fifo_full: fifo_full, fifo_count: fifo_count};

  axil_reg_slave u_regs (
    .bus_clk      (bus_clk),
    .bus_rstn     (bus_rstn),
    .req_i        (req_i),
    .rsp_o        (rsp_o),
    .status_i     (status),
    .digest_i     (digest),
    .ctrl_o       (ctrl),
    .push_valid_o (push_valid),
    .push_data_o  (push_data)
  );

  word_fifo u_fifo (
    .bus_clk     (bus_clk),
    .bus_rstn    (bus_rstn),
    .flush_i     (ctrl.init),   // init empties the queue too
    .push_i      (push_valid),
    .push_data_i (push_data),
    .pop_i       (pop),
    .rd_data_o   (fifo_data),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full),
    .count_o     (fifo_count)
  );

  sha256_core u_core (
    .bus_clk      (bus_clk),
    .bus_rstn     (bus_rstn),
    .ctrl_i       (ctrl),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_data),
    .pop_o        (pop),
    .ready_o      (core_ready),
    .hash_valid_o (hash_valid),
    .digest_o     (digest)
  );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 2,   // 4 ns bus clock
  parameter int RST_CYCLES  = 10
) (
  output logic bus_clk_o,
  output logic bus_rstn_o
);

  initial begin
    bus_clk_o  = 1'b0;
    bus_rstn_o = 1'b0;                      // held low from time zero
    repeat (RST_CYCLES) @(posedge bus_clk_o);
    #1 bus_rstn_o = 1'b1;                   // released in the drive slot
  end

  always #(HALF_PERIOD) bus_clk_o = ~bus_clk_o;

endmodule

//--- dv/tb_sha_hub.sv
`timescale 1ns/10ps
`include "sha_hub_defines.svh"

module tb_sha_hub
  import sha_bus_pkg::*;
  import sha256_pkg::*;
();

  localparam int NUM_MSG = 2;
  // FIPS 180-4 initial hash, H0 first
  localparam digest_t FIPS_IV = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                                 32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

  logic      bus_clk;
  logic      bus_rstn;
  axil_req_t req;
  axil_rsp_t rsp;
  int        errors;
  int        checks;
  int        fails;
  int        tests;
  int        cycles;
  int        limit;
  int        e0;
  int        v;
  word_t     msg_tab [NUM_MSG][32];  // padded message, 16 words per block
  int        blk_tab [NUM_MSG];
  digest_t   dig_tab [NUM_MSG];      // published digests
  string     name_tab [NUM_MSG];

  tb_clk_gen clk0 (.bus_clk_o(bus_clk), .bus_rstn_o(bus_rstn));

  sha_hub_top dut0 (.bus_clk(bus_clk), .bus_rstn(bus_rstn), .req_i(req), .rsp_o(rsp));

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %s (%b) expected %s", $time, name, got.name(), got,
               exp.name());
    end
  endtask

  task automatic check_digest(input string name, input digest_t got, input digest_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // AXI4-Lite master tasks, each starts and ends 1 ns after a rising edge
  // --------------------------------------------------
  task automatic next_drive();
    @(posedge bus_clk);
    #1;
  endtask

  task automatic axil_write(input logic [11:0] addr, input word_t data,
                            output axi_resp_e resp);
    int stall;
    stall       = $urandom % 4;           // bready held back 0 to 3 cycles
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = '1;
    @(negedge bus_clk);
    while (!(rsp.awready && rsp.wready)) @(negedge bus_clk);
    next_drive();                         // handshake taken on that edge
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    repeat (stall) next_drive();
    req.bready = 1'b1;
    @(negedge bus_clk);
    while (!rsp.bvalid) @(negedge bus_clk);
    resp = rsp.bresp;
    next_drive();
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [11:0] addr, output word_t data, output axi_resp_e resp);
    int stall;
    stall       = $urandom % 4;           // rready stall
    req.arvalid = 1'b1;
    req.araddr  = addr;
    @(negedge bus_clk);
    while (!rsp.arready) @(negedge bus_clk);
    next_drive();
    req.arvalid = 1'b0;
    repeat (stall) next_drive();
    req.rready = 1'b1;
    @(negedge bus_clk);
    while (!rsp.rvalid) @(negedge bus_clk);
    data = rsp.rdata;                     // sampled mid cycle, stable
    resp = rsp.rresp;
    next_drive();
    req.rready = 1'b0;
  endtask

  task automatic write_check(input string name, input logic [11:0] addr, input word_t data,
                             input axi_resp_e exp);
    axi_resp_e resp;
    axil_write(addr, data, resp);
    check_resp({name, " bresp"}, resp, exp);
  endtask

  task automatic read_check(input string name, input logic [11:0] addr, input word_t exp);
    word_t     data;
    axi_resp_e resp;
    axil_read(addr, data, resp);
    check_resp({name, " rresp"}, resp, OKAY);
    check_word(name, data, exp);
  endtask

  // hash words sit H7 first at 0x110, so word i is bits 32*i up
  task automatic read_digest(output digest_t d);
    word_t     data;
    axi_resp_e resp;
    for (int i = 0; i < 8; i++) begin
      axil_read(12'(12'h110 + 4 * i), data, resp);
      check_resp("hash rresp", resp, OKAY);
      d[32*i +: 32] = data;
    end
  endtask

  // status layout: ready 0, hash_valid 1, empty 4, full 6, count 12..8
  function automatic word_t status_word(input logic ready, input logic hv, input logic empty,
                                        input logic full, input logic [4:0] count);
    word_t s;
    s       = '0;
    s[0]    = ready;
    s[1]    = hv;
    s[4]    = empty;
    s[6]    = full;
    s[12:8] = count;
    return s;
  endfunction

  task automatic check_regs(input word_t ctrl, input word_t stat, input word_t sha_ctrl,
                            input word_t sha_stat, input digest_t hash);
    digest_t d;
    read_check("REG_CTRL", REG_CTRL, ctrl);
    read_check("REG_STATUS", REG_STATUS, stat);
    read_check("REG_VERSION", REG_VERSION, `SHA_VERSION);
    read_check("REG_SHA_CTRL", REG_SHA_CTRL, sha_ctrl);
    read_check("REG_SHA_STATUS", REG_SHA_STATUS, sha_stat);
    read_digest(d);
    check_digest("hash", d, hash);
  endtask

  task automatic wait_hash_valid();
    word_t     data;
    axi_resp_e resp;
    data = '0;
    while (!data[1]) axil_read(REG_SHA_STATUS, data, resp);  // watchdog bounds this
  endtask

  // init, enable, then one block at a time so hash_valid marks each block end
  task automatic hash_message(input int idx);
    digest_t d;
    write_check("init", REG_SHA_CTRL, 32'h2, OKAY);
    write_check("enable", REG_SHA_CTRL, 32'h1, OKAY);
    for (int b = 0; b < blk_tab[idx]; b++) begin
      for (int k = 0; k < 16; k++) write_check("push", REG_SHA_PUSH, msg_tab[idx][16*b+k], OKAY);
      wait_hash_valid();
    end
    read_digest(d);
    check_digest({name_tab[idx], " digest"}, d, dig_tab[idx]);
  endtask

  task automatic load_table();
    byte c;
    foreach (msg_tab[i, j]) msg_tab[i][j] = '0;
    // "abc", pad bit right after the message, length 24 bits
    msg_tab[0][0]  = 32'h61626380;
    msg_tab[0][15] = 32'h00000018;
    blk_tab[0]     = 1;
    name_tab[0]    = "abc one block";
    dig_tab[0]     = {32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
                      32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad};
    // "abcdbcde...nopq", 448 bits, length spills into a second block
    for (int k = 0; k < 14; k++) begin
      c              = 8'h61 + 8'(k);
      msg_tab[1][k]  = {c, c + 8'd1, c + 8'd2, c + 8'd3};
    end
    msg_tab[1][14] = 32'h80000000;
    msg_tab[1][31] = 32'h000001c0;
    blk_tab[1]     = 2;
    name_tab[1]    = "448-bit two blocks";
    dig_tab[1]     = {32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
                      32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1};
  endtask

  task automatic end_test(input string what, input int err_before);
    tests++;
    if (errors == err_before) $display("test %0d %s: ok", tests, what);
    else begin
      fails++;
      $display("test %0d %s: %0d errors", tests, what, errors - err_before);
    end
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    req = '0;                                  // all DUT inputs idle
    void'($urandom(32'hb463));
    load_table();
    limit = 0;
    foreach (blk_tab[i]) limit += blk_tab[i];
    limit = 20 * limit * 100 + 2000;
    wait (bus_rstn == 1'b1);
    next_drive();

    e0 = errors;
    check_regs(32'h0, 32'h0, 32'h0, status_word(1, 0, 1, 0, 0), FIPS_IV);
    end_test("reset values", e0);

    write_check("global enable", REG_CTRL, 32'h1, OKAY);
    for (int i = 0; i < NUM_MSG; i++) begin  // message table
      e0 = errors;
      hash_message(i);
      end_test(name_tab[i], e0);
    end

    e0 = errors;
    write_check("init core off", REG_SHA_CTRL, 32'h2, OKAY);
    for (int k = 0; k < 16; k++) write_check("fill push", REG_SHA_PUSH, 32'(k), OKAY);
    write_check("overflow push", REG_SHA_PUSH, 32'hdead_beef, SLVERR);
    read_check("status full", REG_SHA_STATUS, status_word(1, 0, 0, 1, 5'd16));
    write_check("init flush", REG_SHA_CTRL, 32'h2, OKAY);
    read_check("status flushed", REG_SHA_STATUS, status_word(1, 0, 1, 0, 0));
    end_test("fifo full and flush", e0);

    e0 = errors;
    read_check("unmapped read", 12'h200, 32'h0);
    write_check("unmapped write", 12'h300, 32'h1, OKAY);  // would set sha enable if aliased
    check_regs(32'h1, 32'h1, 32'h0, status_word(1, 0, 1, 0, 0), FIPS_IV);
    end_test("unmapped access", e0);

    e0 = errors;
    repeat (12) begin
      v = ($urandom % 2 == 0) ? 1 : 2;         // enable or init
      write_check("sha ctrl write", REG_SHA_CTRL, 32'(v), OKAY);
      read_check("sha ctrl readback", REG_SHA_CTRL, (v == 1) ? 32'h1 : 32'h0);
      read_check("version", REG_VERSION, `SHA_VERSION);
    end
    end_test("stalled responses", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, fails, checks, errors);
    if (errors == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hdl/sha_bus_pkg.sv
hdl/sha256_pkg.sv
hdl/word_fifo.sv
hdl/sha256_core.sv
hdl/axil_reg_slave.sv
hdl/sha_hub_top.sv
dv/tb_clk_gen.sv
dv/tb_sha_hub.sv

//--- run_sim.sh
#!/bin/sh
# build the SHA hub testbench with Verilator and run it
# pass or fail is taken from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_sha_hub -o sim_sha_hub \
  && ./obj_dir/sim_sha_hub | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
  && echo "simulation run ok" \
  || { echo "simulation run failed"; exit 1; }
